// File: common/dp_pkg.sv
package dp_pkg;

    // stream geometry
    localparam int LANES  = 4;
    localparam int LANE_W = 32;
    localparam int KEEP_W = LANES * LANE_W / 8;    // one keep bit per byte

    // per column register file
    localparam int RF_DEPTH  = 16;
    localparam int RF_ADDR_W = 4;

    // cycles through one column
    localparam int PE_LAT = 2;

    typedef logic signed [LANE_W-1:0] lane_t;
    typedef lane_t [LANES-1:0]        vec_t;
    typedef logic [KEEP_W-1:0]        keep_t;
    typedef logic [LANES-1:0]         lane_mask_t;
    typedef logic [RF_ADDR_W-1:0]     rf_addr_t;
    typedef logic [31:0]              instr_t;

    // codes 3..7 fall back to nop in the decoder
    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_VMV_VI = 3'd1,
        OP_VMACC  = 3'd2
    } op_e;

    // instruction word, msb first
    typedef struct packed {
        logic signed [15:0] imm;   // splat value for vmv.v.i
        logic [4:0]         rsvd;
        rf_addr_t           rs;    // weight register for vmacc
        rf_addr_t           rd;    // bias register, or vmv target
        logic [2:0]         op;
    } instr_f_t;

endpackage

// File: pe_column/vec_regfile.sv
`timescale 1ns/1ns

module vec_regfile import dp_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_wen,
    input  rf_addr_t i_waddr,
    input  vec_t     i_wdata,
    input  rf_addr_t i_raddr1,
    output vec_t     o_rdata1,
    input  rf_addr_t i_raddr2,
    output vec_t     o_rdata2
);

    vec_t regs [RF_DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                regs[i] <= '0;    // all registers start at zero
            end
        end else if (i_wen) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // async read, new value seen the cycle after the write
    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

endmodule

// File: pe_column/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder import dp_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_exec,
    input  instr_t   i_instr,
    output logic     o_wen,
    output rf_addr_t o_waddr,
    output vec_t     o_wdata,
    output logic     o_mac_en,
    output rf_addr_t o_w_addr,
    output rf_addr_t o_b_addr
);

    instr_f_t fields;
    op_e      op;
    lane_t    imm_ext;

    assign fields  = instr_f_t'(i_instr);
    assign op      = op_e'(fields.op);
    assign imm_ext = {{(LANE_W-16){fields.imm[15]}}, fields.imm};

    // vmv.v.i lands in the register file at the end of the exec cycle
    assign o_wen   = i_exec && (op == OP_VMV_VI);
    assign o_waddr = fields.rd;
    assign o_wdata = {LANES{imm_ext}};   // same value in every lane

    // column mode, held between exec pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            o_mac_en <= 1'b0;
            o_w_addr <= '0;
            o_b_addr <= '0;
        end else if (i_exec) begin
            case (op)
                OP_VMACC: begin
                    o_mac_en <= 1'b1;
                    o_w_addr <= fields.rs;
                    o_b_addr <= fields.rd;
                end
                OP_VMV_VI: begin
                    o_mac_en <= o_mac_en;    // register load only, mode kept
                end
                default: begin
                    o_mac_en <= 1'b0;        // nop and unknown codes pass data
                end
            endcase
        end
    end

endmodule

// File: pe_column/vec_mac_pe.sv
`timescale 1ns/1ns

module vec_mac_pe import dp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_mac_en,
    input  logic       i_valid,
    input  vec_t       i_data,
    input  lane_mask_t i_mask,
    input  logic       i_last,
    input  vec_t       i_weight,
    input  vec_t       i_bias,
    output logic       o_valid,
    output vec_t       o_data,
    output lane_mask_t o_mask,
    output logic       o_last
);

    vec_t       prod_d;
    vec_t       prod_q;
    vec_t       bias_q;
    vec_t       sum_d;
    logic       mac_q;
    logic       valid_q;
    lane_mask_t mask_q;
    logic       last_q;

    // products and sums keep the low 32 bits
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            prod_d[i] = i_mac_en ? lane_t'(i_data[i] * i_weight[i]) : i_data[i];
            sum_d[i]  = mac_q ? lane_t'(prod_q[i] + bias_q[i]) : prod_q[i];
        end
    end

    // stage 1, multiply
    always_ff @(posedge clk) begin
        prod_q <= prod_d;
        bias_q <= i_bias;
        mac_q  <= i_mac_en;
        mask_q <= i_mask;
        last_q <= i_last;
    end

    // stage 2, add bias
    always_ff @(posedge clk) begin
        o_data <= sum_d;
        o_mask <= mask_q;
        o_last <= last_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid_q <= i_valid;
            o_valid <= valid_q;
        end
    end

endmodule

// File: pe_column/pe_column.sv
`timescale 1ns/1ns

module pe_column import dp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_exec,
    input  instr_t     i_instr,
    input  logic       i_valid,
    input  vec_t       i_data,
    input  lane_mask_t i_mask,
    input  logic       i_last,
    output logic       o_valid,
    output vec_t       o_data,
    output lane_mask_t o_mask,
    output logic       o_last
);

    logic     wen;
    rf_addr_t waddr;
    vec_t     wdata;
    logic     mac_en;
    rf_addr_t w_addr;
    rf_addr_t b_addr;
    vec_t     weight;
    vec_t     bias;

    instr_decoder i_instr_decoder (
        .clk(clk),
        .rst(rst),
        .i_exec(i_exec),
        .i_instr(i_instr),
        .o_wen(wen),
        .o_waddr(waddr),
        .o_wdata(wdata),
        .o_mac_en(mac_en),
        .o_w_addr(w_addr),
        .o_b_addr(b_addr)
    );

    // port 1 reads the weight, port 2 the bias
    vec_regfile i_vec_regfile (
        .clk(clk),
        .rst(rst),
        .i_wen(wen),
        .i_waddr(waddr),
        .i_wdata(wdata),
        .i_raddr1(w_addr),
        .o_rdata1(weight),
        .i_raddr2(b_addr),
        .o_rdata2(bias)
    );

    vec_mac_pe i_vec_mac_pe (
        .clk(clk),
        .rst(rst),
        .i_mac_en(mac_en),
        .i_valid(i_valid),
        .i_data(i_data),
        .i_mask(i_mask),
        .i_last(i_last),
        .i_weight(weight),
        .i_bias(bias),
        .o_valid(o_valid),
        .o_data(o_data),
        .o_mask(o_mask),
        .o_last(o_last)
    );

endmodule

// File: rtl/beat_fifo.sv
`timescale 1ns/1ns

module beat_fifo import dp_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_push,
    input  vec_t                       i_data,
    input  keep_t                      i_keep,
    input  logic                       i_last,
    input  logic                       i_pop,
    output vec_t                       o_data,
    output lane_mask_t                 o_mask,
    output keep_t                      o_keep,
    output logic                       o_last,
    output logic                       o_empty,
    output logic                       o_full,
    output logic [$clog2(DEPTH+1)-1:0] o_count
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH+1);
    localparam int KPL    = KEEP_W / LANES;    // keep bits per lane

    vec_t       data_mem [DEPTH];
    lane_mask_t mask_mem [DEPTH];
    logic       last_mem [DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    lane_mask_t        push_mask;

    // lane is valid only with all its bytes kept
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign push_mask[i]          = &i_keep[KPL*i +: KPL];
        assign o_keep[KPL*i +: KPL]  = {KPL{o_mask[i]}};
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            data_mem[wr_ptr] <= i_data;
            mask_mem[wr_ptr] <= push_mask;
            last_mem[wr_ptr] <= i_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            if (i_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry shows as soon as it is stored
    assign o_data  = data_mem[rd_ptr];
    assign o_mask  = mask_mem[rd_ptr];
    assign o_last  = last_mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_count = count;

    // upstream ready / credit logic must keep these from happening
    assert property (@(posedge clk) disable iff (rst) i_push |-> !o_full)
        else $error("beat_fifo: push while full");
    assert property (@(posedge clk) disable iff (rst) i_pop |-> !o_empty)
        else $error("beat_fifo: pop while empty");

endmodule

// File: rtl/stream_ctrl.sv
`timescale 1ns/1ns

module stream_ctrl import dp_pkg::*; #(
    parameter int NUM_COL    = 2,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_done_loader,
    input  logic                            i_in_tvalid,
    input  logic                            i_in_full,
    input  logic                            i_in_empty,
    output logic                            o_tready,
    output logic                            o_pop,
    input  logic                            i_out_push,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] i_out_count,
    input  logic                            i_out_pop,
    input  logic                            i_out_last,
    output logic                            o_done,
    input  logic                            i_instr_req,
    output logic                            o_instr_ack,
    output logic                            o_exec
);

    localparam int CNT_W = $clog2(FIFO_DEPTH+1);
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(FIFO_DEPTH);

    typedef enum logic {ARM_OFF, ARM_ON} arm_e;
    typedef enum logic [1:0] {HS_IDLE, HS_EXEC, HS_ACK} hs_e;

    arm_e             arm_q;
    hs_e              hs_q;
    logic [CNT_W-1:0] in_flight;   // popped but not yet in the output fifo
    logic [CNT_W-1:0] out_free;
    logic             armed;
    logic             last_out;
    logic             credit_ok;

    assign armed    = (arm_q == ARM_ON);
    assign last_out = i_out_pop & i_out_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            arm_q <= ARM_OFF;
        end else begin
            case (arm_q)
                ARM_OFF: if (i_done_loader) arm_q <= ARM_ON;
                ARM_ON:  if (last_out) arm_q <= ARM_OFF;
            endcase
        end
    end

    assign o_done   = armed & last_out;
    assign o_tready = armed & ~i_in_full;

    // pop only if every beat in the columns still has an output slot
    assign out_free  = DEPTH_C - i_out_count;
    assign credit_ok = (out_free > in_flight);
    assign o_pop     = armed & ~i_in_empty & credit_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            case ({o_pop, i_out_push})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // four phase req/ack, one exec cycle per request
    always_ff @(posedge clk) begin
        if (rst) begin
            hs_q <= HS_IDLE;
        end else begin
            case (hs_q)
                HS_IDLE: if (i_instr_req) hs_q <= HS_EXEC;
                HS_EXEC: hs_q <= HS_ACK;
                HS_ACK:  if (!i_instr_req) hs_q <= HS_IDLE;
                default: hs_q <= HS_IDLE;
            endcase
        end
    end

    assign o_exec      = (hs_q == HS_EXEC);
    assign o_instr_ack = (hs_q == HS_ACK);

    // column pipes hold at most PE_LAT beats each
    assert property (@(posedge clk) disable iff (rst) in_flight <= CNT_W'(PE_LAT * NUM_COL))
        else $error("stream_ctrl: in-flight count above column capacity");
    // accepted beat must be sitting in the input fifo next cycle
    assert property (@(posedge clk) disable iff (rst) i_in_tvalid && o_tready |=> !i_in_empty)
        else $error("stream_ctrl: accepted beat not held by input fifo");

endmodule

// File: rtl/dp_top.sv
`timescale 1ns/1ns

module dp_top import dp_pkg::*; #(
    parameter int NUM_COL    = 2,
    parameter int FIFO_DEPTH = 16
) (
    input  logic   clk,
    input  logic   rst,
    input  vec_t   i_tdata,
    input  keep_t  i_tkeep,
    input  logic   i_tlast,
    input  logic   i_tvalid,
    output logic   o_tready,
    output vec_t   o_tdata,
    output keep_t  o_tkeep,
    output logic   o_tlast,
    output logic   o_tvalid,
    input  logic   i_tready,
    input  logic   i_done_loader,
    output logic   o_done,
    input  instr_t i_instr [NUM_COL],
    input  logic   i_instr_req,
    output logic   o_instr_ack
);

    localparam int CNT_W = $clog2(FIFO_DEPTH+1);
    localparam int KPL   = KEEP_W / LANES;

    logic             in_push;
    logic             in_pop;
    logic             in_empty;
    logic             in_full;
    logic             out_pop;
    logic             out_empty;
    logic [CNT_W-1:0] out_count;
    logic             exec;
    keep_t            out_keep;

    // index k is the input of column k, index NUM_COL the chain output
    logic       col_valid [NUM_COL+1];
    vec_t       col_data  [NUM_COL+1];
    lane_mask_t col_mask  [NUM_COL+1];
    logic       col_last  [NUM_COL+1];

    assign in_push      = i_tvalid & o_tready;
    assign col_valid[0] = in_pop;          // fall-through head enters column 0
    assign o_tvalid     = ~out_empty;
    assign out_pop      = o_tvalid & i_tready;

    beat_fifo #(.DEPTH(FIFO_DEPTH)) i_in_fifo (
        .clk(clk), .rst(rst),
        .i_push(in_push), .i_data(i_tdata), .i_keep(i_tkeep), .i_last(i_tlast),
        .i_pop(in_pop),
        .o_data(col_data[0]), .o_mask(col_mask[0]), .o_keep(), .o_last(col_last[0]),
        .o_empty(in_empty), .o_full(in_full), .o_count()
    );

    stream_ctrl #(.NUM_COL(NUM_COL), .FIFO_DEPTH(FIFO_DEPTH)) i_stream_ctrl (
        .clk(clk), .rst(rst),
        .i_done_loader(i_done_loader), .i_in_tvalid(i_tvalid),
        .i_in_full(in_full), .i_in_empty(in_empty),
        .o_tready(o_tready), .o_pop(in_pop),
        .i_out_push(col_valid[NUM_COL]), .i_out_count(out_count),
        .i_out_pop(out_pop), .i_out_last(o_tlast), .o_done(o_done),
        .i_instr_req(i_instr_req), .o_instr_ack(o_instr_ack), .o_exec(exec)
    );

    for (genvar k = 0; k < NUM_COL; k++) begin : g_col
        pe_column i_pe_column (
            .clk(clk), .rst(rst), .i_exec(exec), .i_instr(i_instr[k]),
            .i_valid(col_valid[k]), .i_data(col_data[k]),
            .i_mask(col_mask[k]), .i_last(col_last[k]),
            .o_valid(col_valid[k+1]), .o_data(col_data[k+1]),
            .o_mask(col_mask[k+1]), .o_last(col_last[k+1])
        );
    end

    // lane mask back to byte keep for the output fifo
    for (genvar i = 0; i < LANES; i++) begin : g_keep
        assign out_keep[KPL*i +: KPL] = {KPL{col_mask[NUM_COL][i]}};
    end

    beat_fifo #(.DEPTH(FIFO_DEPTH)) i_out_fifo (
        .clk(clk), .rst(rst),
        .i_push(col_valid[NUM_COL]), .i_data(col_data[NUM_COL]), .i_keep(out_keep),
        .i_last(col_last[NUM_COL]), .i_pop(out_pop),
        .o_data(o_tdata), .o_mask(), .o_keep(o_tkeep), .o_last(o_tlast),
        .o_empty(out_empty), .o_full(), .o_count(out_count)
    );

endmodule

// File: bench/tb_dp_top.sv
`timescale 1ns/1ns

module tb_dp_top;
    import dp_pkg::*;

    localparam int NUM_COL     = 2;
    localparam int FIFO_DEPTH  = 16;
    localparam int TOTAL_BEATS = 20 + 30 + 64 + 24 + 20;
    localparam int TIMEOUT_CYC = 60 * TOTAL_BEATS + 500;
    localparam int KPL         = KEEP_W / LANES;

    logic   clk;
    logic   rst;
    vec_t   i_tdata;
    keep_t  i_tkeep;
    logic   i_tlast;
    logic   i_tvalid;
    logic   o_tready;
    vec_t   o_tdata;
    keep_t  o_tkeep;
    logic   o_tlast;
    logic   o_tvalid;
    logic   i_tready;
    logic   i_done_loader;
    logic   o_done;
    instr_t i_instr [NUM_COL];
    logic   i_instr_req;
    logic   o_instr_ack;

    // what the columns were programmed with
    lane_t [NUM_COL-1:0] cfg_w;
    lane_t [NUM_COL-1:0] cfg_b;
    logic  [NUM_COL-1:0] cfg_mac;

    vec_t  exp_data [$];
    keep_t exp_keep [$];
    logic  exp_last [$];

    int    seed = 40004;
    int    err_count = 0;
    int    beats_checked = 0;
    int    cycle_cnt = 0;
    string test_name = "reset_idle";
    logic  in_fire = 1'b0;     // input transfer at the coming edge
    logic  done_seen = 1'b0;

    dp_top #(.NUM_COL(NUM_COL), .FIFO_DEPTH(FIFO_DEPTH)) i_dp_top (
        .clk(clk), .rst(rst),
        .i_tdata(i_tdata), .i_tkeep(i_tkeep), .i_tlast(i_tlast), .i_tvalid(i_tvalid),
        .o_tready(o_tready),
        .o_tdata(o_tdata), .o_tkeep(o_tkeep), .o_tlast(o_tlast), .o_tvalid(o_tvalid),
        .i_tready(i_tready),
        .i_done_loader(i_done_loader), .o_done(o_done),
        .i_instr(i_instr), .i_instr_req(i_instr_req), .o_instr_ack(o_instr_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles in %s, stream never finished", cycle_cnt,
                     test_name);
            $display("beats checked: %0d, errors: %0d", beats_checked, err_count + 1);
            $display("Errors found");
            $finish;
        end
    end

    // each column in mac mode maps a lane to x*w+b, 32-bit wrap
    function automatic vec_t ref_beat(input vec_t x, input lane_t [NUM_COL-1:0] w,
                                      input lane_t [NUM_COL-1:0] b,
                                      input logic [NUM_COL-1:0] mac);
        vec_t y;
        y = x;
        for (int c = 0; c < NUM_COL; c++) begin
            if (mac[c]) begin
                for (int i = 0; i < LANES; i++) begin
                    y[i] = y[i] * w[c] + b[c];
                end
            end
        end
        return y;
    endfunction

    // a lane survives only with all four keep bits set
    function automatic keep_t ref_keep(input keep_t k);
        keep_t r;
        for (int i = 0; i < LANES; i++) begin
            r[KPL*i +: KPL] = {KPL{&k[KPL*i +: KPL]}};
        end
        return r;
    endfunction

    function automatic instr_t make_instr(input op_e op, input rf_addr_t rd, input rf_addr_t rs,
                                          input int imm);
        return {imm[15:0], 5'b00000, rs, rd, op};
    endfunction

    task automatic check_vec(input string name, input vec_t exp, input vec_t act,
                             input keep_t keep);
        for (int i = 0; i < LANES; i++) begin
            if (keep[KPL*i] && act[i] !== exp[i]) begin
                $display("FAILED %s lane %0d: expected %0d, actual %0d", name, i, exp[i],
                         act[i]);
                err_count++;
            end
        end
    endtask

    task automatic check_keep(input string name, input keep_t exp, input keep_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    // queue at input transfer, compare at output transfer
    always @(negedge clk) begin : watch_streams
        vec_t  e_data;
        keep_t e_keep;
        logic  e_last;
        logic  out_fire;
        if (!rst) begin
            in_fire  = i_tvalid && o_tready;
            out_fire = o_tvalid && i_tready;
            e_last   = 1'b0;
            if (in_fire) begin
                exp_data.push_back(ref_beat(i_tdata, cfg_w, cfg_b, cfg_mac));
                exp_keep.push_back(ref_keep(i_tkeep));
                exp_last.push_back(i_tlast);
            end
            if (out_fire) begin
                if (exp_data.size() == 0) begin
                    $display("%s: output beat appeared while no beat was expected", test_name);
                    err_count++;
                end else begin
                    e_data = exp_data.pop_front();
                    e_keep = exp_keep.pop_front();
                    e_last = exp_last.pop_front();
                    check_vec({test_name, " data"}, e_data, o_tdata, e_keep);
                    check_keep({test_name, " keep"}, e_keep, o_tkeep);
                    check_bit({test_name, " last"}, e_last, o_tlast);
                    beats_checked++;
                end
            end
            check_bit({test_name, " done"}, out_fire && e_last, o_done);
            if (o_done) done_seen = 1'b1;
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // four phase req/ack, words held until ack
    task automatic run_instr(input instr_t w0, input instr_t w1);
        int waited;
        check_bit({test_name, " ack before req"}, 1'b0, o_instr_ack);
        i_instr[0]  = w0;
        i_instr[1]  = w1;
        i_instr_req = 1'b1;
        waited      = 0;
        while (!o_instr_ack && waited < 16) begin
            tick();
            waited++;
        end
        if (!o_instr_ack) begin
            $display("%s: instruction ack never rose after req", test_name);
            err_count++;
        end
        i_instr_req = 1'b0;
        waited      = 0;
        while (o_instr_ack && waited < 16) begin
            tick();
            waited++;
        end
        if (o_instr_ack) begin
            $display("%s: instruction ack stayed high after req fell", test_name);
            err_count++;
        end
    endtask

    // weight in v1, bias in v2, then vmacc or nop per column
    task automatic configure(input int w0, input int b0, input bit mac0,
                             input int w1, input int b1, input bit mac1);
        run_instr(make_instr(OP_VMV_VI, 4'd1, 4'd0, w0), make_instr(OP_VMV_VI, 4'd1, 4'd0, w1));
        run_instr(make_instr(OP_VMV_VI, 4'd2, 4'd0, b0), make_instr(OP_VMV_VI, 4'd2, 4'd0, b1));
        run_instr(mac0 ? make_instr(OP_VMACC, 4'd2, 4'd1, 0) : make_instr(OP_NOP, 4'd0, 4'd0, 0),
                  mac1 ? make_instr(OP_VMACC, 4'd2, 4'd1, 0) : make_instr(OP_NOP, 4'd0, 4'd0, 0));
        cfg_w[0]   = w0;
        cfg_b[0]   = b0;
        cfg_mac[0] = mac0;
        cfg_w[1]   = w1;
        cfg_b[1]   = b1;
        cfg_mac[1] = mac1;
    endtask

    task automatic load_beat(input logic last, input bit part_keep);
        logic kept;
        for (int i = 0; i < LANES; i++) begin
            i_tdata[i] = $random(seed);
            kept = !part_keep || ($random(seed) % 2 == 0);
            i_tkeep[KPL*i +: KPL] = {KPL{kept}};
        end
        i_tlast  = last;
        i_tvalid = 1'b1;
    endtask

    task automatic send_stream(input string name, input int n, input bit part_keep,
                               input bit bp);
        int   sent;
        logic lost;
        test_name     = name;
        sent          = 0;
        lost          = 1'b0;
        done_seen     = 1'b0;
        i_done_loader = 1'b1;       // arm pulse
        tick();
        i_done_loader = 1'b0;
        load_beat(n == 1, part_keep);
        while (!done_seen && !lost) begin
            tick();
            if (in_fire) begin
                sent++;
                if (sent < n) load_beat(sent == n - 1, part_keep);
                else i_tvalid = 1'b0;
            end
            i_tready = bp ? ($random(seed) & 1) : 1'b1;
            if (sent == n && exp_data.size() == 0 && !done_seen) begin
                $display("%s: last beat left without a done pulse", name);
                err_count++;
                lost = 1'b1;
            end
        end
        i_tready = 1'b1;
        check_bit({name, " tready after done"}, 1'b0, o_tready);
        if (exp_data.size() != 0) begin
            $display("%s: %0d beats never came out", name, exp_data.size());
            err_count++;
        end
    endtask

    initial begin
        rst           = 1'b1;
        i_tdata       = '0;
        i_tkeep       = '0;
        i_tlast       = 1'b0;
        i_tvalid      = 1'b0;
        i_tready      = 1'b1;
        i_done_loader = 1'b0;
        i_instr[0]    = '0;
        i_instr[1]    = '0;
        i_instr_req   = 1'b0;
        cfg_w         = '0;
        cfg_b         = '0;
        cfg_mac       = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet until armed
        repeat (10) begin
            tick();
            check_bit("reset_idle tready", 1'b0, o_tready);
            check_bit("reset_idle tvalid", 1'b0, o_tvalid);
            check_bit("reset_idle done", 1'b0, o_done);
            check_bit("reset_idle ack", 1'b0, o_instr_ack);
        end

        test_name = "bypass";
        configure(0, 0, 0, 0, 0, 0);
        send_stream("bypass", 20, 1'b0, 1'b0);

        test_name = "mac_chain";
        configure(3, -5, 1, -2, 7, 1);
        send_stream("mac_chain", 30, 1'b0, 1'b0);
        send_stream("backpressure", 64, 1'b0, 1'b1);

        test_name = "partial_keep";
        configure(1234, -77, 1, -9, 32000, 1);
        send_stream("partial_keep", 24, 1'b1, 1'b0);

        test_name = "mixed";
        configure(5, -11, 1, 0, 0, 0);   // column 1 stays at nop
        send_stream("mixed", 20, 1'b0, 1'b0);

        repeat (4) tick();
        $display("beats checked: %0d, errors: %0d", beats_checked, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: compile.f
common/dp_pkg.sv
pe_column/vec_regfile.sv
pe_column/instr_decoder.sv
pe_column/vec_mac_pe.sv
pe_column/pe_column.sv
rtl/beat_fifo.sv
rtl/stream_ctrl.sv
rtl/dp_top.sv
bench/tb_dp_top.sv

// File: Bender.yml
package:
  name: dp_top

sources:
  - files:
      - common/dp_pkg.sv
      - pe_column/vec_regfile.sv
      - pe_column/instr_decoder.sv
      - pe_column/vec_mac_pe.sv
      - pe_column/pe_column.sv
      - rtl/beat_fifo.sv
      - rtl/stream_ctrl.sv
      - rtl/dp_top.sv
  - target: test
    files:
      - bench/tb_dp_top.sv
